// File: source/umi_pkg.sv
// UMI packet layout shared by the link transmit design.
// Command field positions, opcode values and the packed packet type.
// Import by wildcard in any module that handles a UMI packet.

`default_nettype none

package umi_pkg;

   //############################################################
   // Field widths
   //############################################################
   localparam int UMI_CW = 32;                 // Command width
   localparam int UMI_AW = 32;                 // Address width
   localparam int UMI_DW = 64;                 // Data width

   // Command field positions
   localparam int UMI_OPCODE_LSB = 0;
   localparam int UMI_OPCODE_MSB = 4;
   localparam int UMI_SIZE_LSB   = 5;          // log2 of word size
   localparam int UMI_SIZE_MSB   = 7;
   localparam int UMI_LEN_LSB    = 8;          // Words minus one
   localparam int UMI_LEN_MSB    = 15;

   //############################################################
   // Opcodes
   //############################################################
   localparam logic [4:0] UMI_INVALID    = 5'd0;
   localparam logic [4:0] UMI_REQ_READ   = 5'd1;
   localparam logic [4:0] UMI_RESP_READ  = 5'd2;
   localparam logic [4:0] UMI_REQ_WRITE  = 5'd3;
   localparam logic [4:0] UMI_RESP_WRITE = 5'd4;
   localparam logic [4:0] UMI_REQ_POSTED = 5'd5;
   localparam logic [4:0] UMI_REQ_LINK   = 5'd14;
   localparam logic [4:0] UMI_RESP_LINK  = 5'd15;

   // Bytes on the wire for the short packet classes
   localparam int UMI_HDR_BYTES = 12;          // cmd + dstaddr + srcaddr
   localparam int UMI_CMD_BYTES = 4;           // cmd alone

   // Full packet, cmd in the low bits so it leaves first
   typedef struct packed {
      logic [UMI_DW-1:0] data;
      logic [UMI_AW-1:0] srcaddr;
      logic [UMI_AW-1:0] dstaddr;
      logic [UMI_CW-1:0] cmd;
   } umi_packet_t;

endpackage

`default_nettype wire

// File: source/lumi_pkg.sv
// Link level constants for the transmit side.
// Counter widths, PHY width and the lane class used by the serializer.

`default_nettype none

package lumi_pkg;

   //############################################################
   // Link sizing
   //############################################################
   localparam int LUMI_IOW       = 64;         // PHY line width in bits
   localparam int LUMI_PKT_BYTES = 20;         // Largest packet on the wire
   localparam int LUMI_CNT_W     = 16;         // Credit and status counters
   localparam int LUMI_LEN_W     = 5;          // Byte and line counts, up to 20

   // Owner of the packet in the shift register
   typedef enum logic [1:0] {
      CLASS_REQ  = 2'b01,
      CLASS_RESP = 2'b10
   } lumi_class_e;

endpackage

`default_nettype wire

// File: source/lumi_lane_if.sv
// Handshake between one channel lane and the serializer.
// The lane offers a sized packet, the serializer grants and reports lines sent.

`timescale 1ns/1ps
`default_nettype none

interface lumi_lane_if
   import umi_pkg::*, lumi_pkg::*;
   ();

   logic                  valid;      // Packet offered with enough credit
   umi_packet_t           pkt;        // Packet payload
   logic [LUMI_LEN_W-1:0] nbytes;     // Bytes on the wire
   logic [LUMI_LEN_W-1:0] nlines;     // PHY lines at current width
   logic                  ready;      // Serializer takes the packet
   logic                  line_sent;  // One line of this lane left the PHY port

   // Lane side
   modport lane (
      output valid, pkt, nbytes, nlines,
      input  ready, line_sent
   );

   // Serializer side
   modport tx (
      input  valid, pkt, nbytes, nlines,
      output ready, line_sent
   );

endinterface

`default_nettype wire

// File: source/lumi_lane.sv
// Per channel lane of the link transmitter.
// Sizes the incoming packet, checks it against remote credits and counts stalls.
// Combinational from the UMI port to the serializer interface.

`timescale 1ns/1ps
`default_nettype none

module lumi_lane
   import umi_pkg::*, lumi_pkg::*;
   (
      input  logic                  clk,
      input  logic                  nreset,
      input  logic                  csr_crdt_en,  // 0 = infinite credit
      input  logic [1:0]            csr_iowidth,  // Line is 2^n bytes
      input  logic                  umi_valid,
      input  umi_packet_t           umi_pkt,
      output logic                  umi_ready,
      input  logic [LUMI_CNT_W-1:0] rmt_crdt,     // Lines granted by far side
      output logic [LUMI_CNT_W-1:0] stall_cnt,    // Cycles blocked on credit
      lumi_lane_if.lane             tx
   );

   //############################################################
   // Command decode
   //############################################################
   logic [4:0]            opcode;
   logic [2:0]            cmd_size;
   logic [7:0]            cmd_len;
   logic                  cmd_only;
   logic                  no_data;
   logic [15:0]           data_bytes_raw;
   logic [3:0]            data_bytes;
   logic [LUMI_LEN_W-1:0] nbytes;
   logic [3:0]            line_bytes;
   logic [LUMI_LEN_W:0]   nlines_raw;            // One extra bit for round up
   logic [LUMI_LEN_W-1:0] nlines;
   logic [LUMI_CNT_W-1:0] sent_cnt;
   logic [LUMI_CNT_W-1:0] crdt_avail;
   logic                  crdt_ok;

   assign opcode   = umi_pkt.cmd[UMI_OPCODE_MSB:UMI_OPCODE_LSB];
   assign cmd_size = umi_pkt.cmd[UMI_SIZE_MSB:UMI_SIZE_LSB];
   assign cmd_len  = umi_pkt.cmd[UMI_LEN_MSB:UMI_LEN_LSB];

   // Opcode class, atomics and user ops fall through as data
   always_comb
   begin
      cmd_only = 1'b0;
      no_data  = 1'b0;
      case (opcode)
         UMI_INVALID,
         UMI_REQ_LINK,
         UMI_RESP_LINK:  cmd_only = 1'b1;   // Header word only
         UMI_REQ_READ,
         UMI_RESP_WRITE: no_data  = 1'b1;   // Addresses, no payload
         default:        no_data  = 1'b0;   // Read resp, write, posted carry data
      endcase
   end

   // (len+1) << size, capped to the 64-bit data field
   assign data_bytes_raw = ({8'h00, cmd_len} + 16'd1) << cmd_size;
   assign data_bytes     = (data_bytes_raw > 16'd8) ? 4'd8 : data_bytes_raw[3:0];

   always_comb
   begin
      if (cmd_only)
         nbytes = LUMI_LEN_W'(UMI_CMD_BYTES);
      else if (no_data)
         nbytes = LUMI_LEN_W'(UMI_HDR_BYTES);
      else
         nbytes = LUMI_LEN_W'(UMI_HDR_BYTES) + {1'b0, data_bytes};
   end

   //############################################################
   // Line count, rounded up
   //############################################################
   assign line_bytes = 4'd1 << csr_iowidth;
   assign nlines_raw = ({1'b0, nbytes} + {{(LUMI_LEN_W-3){1'b0}}, line_bytes}
                        - {{LUMI_LEN_W{1'b0}}, 1'b1}) >> csr_iowidth;
   assign nlines     = nlines_raw[LUMI_LEN_W-1:0];    // Max 20, fits

   //############################################################
   // Credit tracking
   //############################################################
   // Lines sent so far, wraps with the remote counter
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         sent_cnt <= '0;
      else if (tx.line_sent)
         sent_cnt <= sent_cnt + 1'b1;
   end

   // Line leaving this cycle is already spent
   assign crdt_avail = rmt_crdt - sent_cnt - {{(LUMI_CNT_W-1){1'b0}}, tx.line_sent};
   assign crdt_ok    = !csr_crdt_en || (crdt_avail >= {{(LUMI_CNT_W-LUMI_LEN_W){1'b0}}, nlines});

   // Blocked cycles for the status CSR
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         stall_cnt <= '0;
      else if (umi_valid && !crdt_ok)
         stall_cnt <= stall_cnt + 1'b1;
   end

   //############################################################
   // Serializer side
   //############################################################
   assign tx.valid  = umi_valid && crdt_ok;
   assign tx.pkt    = umi_pkt;
   assign tx.nbytes = nbytes;
   assign tx.nlines = nlines;

   // Accept exactly when the serializer loads
   assign umi_ready = tx.ready && crdt_ok;

   // A line of this lane leaves only against remaining remote credit
   a_line_has_credit: assert property (@(posedge clk) disable iff (!nreset)
      (csr_crdt_en && tx.line_sent) |-> (rmt_crdt != sent_cnt));

endmodule

`default_nettype wire

// File: source/lumi_serializer.sv
// Arbiter and shift register between the two lanes and the PHY port.
// Responses win over requests; the packet leaves LSB first, one line per transfer.

`timescale 1ns/1ps
`default_nettype none

module lumi_serializer
   import umi_pkg::*, lumi_pkg::*;
   (
      input  logic                clk,
      input  logic                nreset,
      input  logic                csr_en,        // 0 = take no new packets
      input  logic [1:0]          csr_iowidth,   // Line is 2^n bytes
      lumi_lane_if.tx             req,
      lumi_lane_if.tx             resp,
      output logic [LUMI_IOW-1:0] phy_txdata,
      output logic                phy_txvld,
      input  logic                phy_txready
   );

   localparam int PKT_W = 8 * LUMI_PKT_BYTES;   // 160 bit shift register

   logic [PKT_W-1:0]      shiftreg;
   logic [LUMI_LEN_W-1:0] lines_left;
   lumi_class_e           owner;
   logic                  line_xfer;
   logic                  last_line;
   logic                  can_load;
   logic                  load_req;
   logic                  load_resp;
   logic                  load;
   umi_packet_t           load_pkt;
   logic [LUMI_LEN_W-1:0] load_nbytes;
   logic [LUMI_LEN_W-1:0] load_nlines;
   logic [PKT_W-1:0]      byte_keep;
   logic [6:0]            shift_bits;

   //############################################################
   // Arbitration
   //############################################################
   assign line_xfer = phy_txvld && phy_txready;
   assign last_line = line_xfer && (lines_left == LUMI_LEN_W'(1));

   // Empty, or last line going out this cycle
   assign can_load = csr_en && ((lines_left == '0) || last_line);

   // Ready only toward a lane that offers, response first
   assign resp.ready = can_load && resp.valid;
   assign req.ready  = can_load && req.valid && !resp.valid;

   assign load_resp = resp.valid && resp.ready;
   assign load_req  = req.valid && req.ready;
   assign load      = load_resp || load_req;

   // Winner mux
   assign load_pkt    = load_resp ? resp.pkt    : req.pkt;
   assign load_nbytes = load_resp ? resp.nbytes : req.nbytes;
   assign load_nlines = load_resp ? resp.nlines : req.nlines;

   // Zero bytes past the packet end
   assign byte_keep = ~({PKT_W{1'b1}} << {load_nbytes, 3'b000});

   //############################################################
   // Shift register
   //############################################################
   assign shift_bits = 7'd8 << csr_iowidth;     // 8 to 64 bits per line

   // Packet bytes, lowest line on the PHY
   always_ff @(posedge clk)
   begin
      if (load)
         shiftreg <= load_pkt & byte_keep;
      else if (line_xfer)
         shiftreg <= shiftreg >> shift_bits;
   end

   // Line count and owner
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         lines_left <= '0;
         owner      <= CLASS_REQ;
      end
      else if (load)
      begin
         lines_left <= load_nlines;
         owner      <= load_resp ? CLASS_RESP : CLASS_REQ;
      end
      else if (line_xfer)
         lines_left <= lines_left - 1'b1;
   end

   //############################################################
   // PHY port
   //############################################################
   assign phy_txvld  = (lines_left != '0);
   assign phy_txdata = shiftreg[LUMI_IOW-1:0];  // Upper bytes unused below 8B lines

   // Credit return to the owning lane
   assign req.line_sent  = line_xfer && (owner == CLASS_REQ);
   assign resp.line_sent = line_xfer && (owner == CLASS_RESP);

   // PHY sees a held line while stalled
   a_stall_hold: assert property (@(posedge clk) disable iff (!nreset)
      (phy_txvld && !phy_txready) |=> (phy_txvld && $stable(phy_txdata)));

   // Lanes offer at least one line and no more bytes than the register holds
   a_load_fits: assert property (@(posedge clk) disable iff (!nreset)
      load |-> (load_nlines != '0 && load_nbytes <= LUMI_LEN_W'(LUMI_PKT_BYTES)));

endmodule

`default_nettype wire

// File: source/lumi_tx.sv
// Link transmit top level.
// Two UMI input channels, remote credit inputs, stall status and the PHY line port.

`timescale 1ns/1ps
`default_nettype none

module lumi_tx
   import umi_pkg::*, lumi_pkg::*;
   (
      input  logic                  clk,
      input  logic                  nreset,
      input  logic                  csr_en,
      input  logic                  csr_crdt_en,
      input  logic [1:0]            csr_iowidth,
      // Request channel
      input  logic                  umi_req_in_valid,
      input  logic [UMI_CW-1:0]     umi_req_in_cmd,
      input  logic [UMI_AW-1:0]     umi_req_in_dstaddr,
      input  logic [UMI_AW-1:0]     umi_req_in_srcaddr,
      input  logic [UMI_DW-1:0]     umi_req_in_data,
      output logic                  umi_req_in_ready,
      // Response channel
      input  logic                  umi_resp_in_valid,
      input  logic [UMI_CW-1:0]     umi_resp_in_cmd,
      input  logic [UMI_AW-1:0]     umi_resp_in_dstaddr,
      input  logic [UMI_AW-1:0]     umi_resp_in_srcaddr,
      input  logic [UMI_DW-1:0]     umi_resp_in_data,
      output logic                  umi_resp_in_ready,
      // Credits and status
      input  logic [LUMI_CNT_W-1:0] rmt_crdt_req,
      input  logic [LUMI_CNT_W-1:0] rmt_crdt_resp,
      output logic [31:0]           csr_crdt_status,   // {resp stalls, req stalls}
      // PHY
      output logic [LUMI_IOW-1:0]   phy_txdata,
      output logic                  phy_txvld,
      input  logic                  phy_txready
   );

   umi_packet_t req_pkt;
   umi_packet_t resp_pkt;

   // Plain ports into packets
   assign req_pkt  = '{data:    umi_req_in_data,
                       srcaddr: umi_req_in_srcaddr,
                       dstaddr: umi_req_in_dstaddr,
                       cmd:     umi_req_in_cmd};
   assign resp_pkt = '{data:    umi_resp_in_data,
                       srcaddr: umi_resp_in_srcaddr,
                       dstaddr: umi_resp_in_dstaddr,
                       cmd:     umi_resp_in_cmd};

   lumi_lane_if req_if ();
   lumi_lane_if resp_if ();

   //############################################################
   // Lanes
   //############################################################
   lumi_lane lane_req (
      .clk         (clk),
      .nreset      (nreset),
      .csr_crdt_en (csr_crdt_en),
      .csr_iowidth (csr_iowidth),
      .umi_valid   (umi_req_in_valid),
      .umi_pkt     (req_pkt),
      .umi_ready   (umi_req_in_ready),
      .rmt_crdt    (rmt_crdt_req),
      .stall_cnt   (csr_crdt_status[15:0]),
      .tx          (req_if.lane)
   );

   lumi_lane lane_resp (
      .clk         (clk),
      .nreset      (nreset),
      .csr_crdt_en (csr_crdt_en),
      .csr_iowidth (csr_iowidth),
      .umi_valid   (umi_resp_in_valid),
      .umi_pkt     (resp_pkt),
      .umi_ready   (umi_resp_in_ready),
      .rmt_crdt    (rmt_crdt_resp),
      .stall_cnt   (csr_crdt_status[31:16]),
      .tx          (resp_if.lane)
   );

   // Mux and shift out
   lumi_serializer serializer (
      .clk         (clk),
      .nreset      (nreset),
      .csr_en      (csr_en),
      .csr_iowidth (csr_iowidth),
      .req         (req_if.tx),
      .resp        (resp_if.tx),
      .phy_txdata  (phy_txdata),
      .phy_txvld   (phy_txvld),
      .phy_txready (phy_txready)
   );

endmodule

`default_nettype wire

// File: include/lumi_tb_util.svh
// Shared testbench helpers, included inside the testbench module body.
// Seeded LFSR for stimulus, the single value check, error counters and the watchdog limit.

`ifndef LUMI_TB_UTIL_SVH
`define LUMI_TB_UTIL_SVH

   // 30 packets of up to 20 lines, 8 cycles a line under back-pressure, plus margin
   localparam int CYCLE_LIMIT = 30 * 20 * 8 + 200;

   int          err_cnt    = 0;
   int          check_cnt  = 0;
   int          cycle_cnt  = 0;              // Bumped on every rising edge
   logic [31:0] lfsr_state = 32'd67736;

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic lfsr_step();
      logic out;
      out        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out)
         lfsr_state = lfsr_state ^ 32'h8020_0003;   // Feedback taps
      return out;
   endfunction

   // One step per bit taken
   function automatic logic [31:0] lfsr_word();
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < 32; i++)
         v = {v[30:0], lfsr_step()};
      return v;
   endfunction

   // Compare and report on mismatch
   task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                              input string msg);
      check_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
      end
   endtask

`endif

// File: tests/lumi_tx_tb.sv
// Directed testbench for the link transmit top level.
// Drives both UMI channels, gathers PHY lines into a byte queue and compares
// them with packets sized by the UMI rules.

`timescale 1ns/1ps
`default_nettype none

module lumi_tx_tb
   import umi_pkg::*;
   ();

   logic        clk = 1'b0;
   logic        nreset;
   logic        csr_en;
   logic        csr_crdt_en;
   logic [1:0]  csr_iowidth;
   logic        umi_req_in_valid;
   logic [31:0] umi_req_in_cmd;
   logic [31:0] umi_req_in_dstaddr;
   logic [31:0] umi_req_in_srcaddr;
   logic [63:0] umi_req_in_data;
   logic        umi_req_in_ready;
   logic        umi_resp_in_valid;
   logic [31:0] umi_resp_in_cmd;
   logic [31:0] umi_resp_in_dstaddr;
   logic [31:0] umi_resp_in_srcaddr;
   logic [63:0] umi_resp_in_data;
   logic        umi_resp_in_ready;
   logic [15:0] rmt_crdt_req;
   logic [15:0] rmt_crdt_resp;
   logic [31:0] csr_crdt_status;
   logic [63:0] phy_txdata;
   logic        phy_txvld;
   logic        phy_txready;

   logic [7:0]  rx_q[$];                  // Bytes seen on the PHY port
   logic [7:0]  exp_q[$];                 // Expected bytes, padded to whole lines
   bit          exp_mask[$];              // Set where the byte is part of a packet
   int          rx_lines         = 0;
   int          exp_lines        = 0;
   int          req_lines_total  = 0;     // Request lines ever queued
   int          resp_lines_total = 0;     // Response lines ever queued
   bit          bp_en            = 1'b0;
   bit          held             = 1'b0;
   logic [63:0] held_data;

   `include "lumi_tb_util.svh"

   lumi_tx lumi_tx_i (.*);

   always #50 clk = ~clk;                 // 100 ns period

   // Watchdog
   always @(posedge clk)
   begin
      cycle_cnt++;
      if (cycle_cnt >= CYCLE_LIMIT)
      begin
         $display("Timeout after %0d cycles, run did not complete", CYCLE_LIMIT);
         $display(">>> FAIL");
         $finish;
      end
   end

   // PHY back-pressure, one slot after the stimulus
   always @(posedge clk)
   begin
      #2;
      phy_txready = bp_en ? lfsr_step() : 1'b1;
   end

   // PHY monitor, sampled mid cycle where everything is settled
   always @(negedge clk)
   begin
      if (held)
      begin
         check_equal(64'(phy_txvld), 64'd1, "valid dropped under stall");
         check_equal(phy_txdata, held_data, "data changed under stall");
      end
      held      = nreset && phy_txvld && !phy_txready;
      held_data = phy_txdata;
      if (nreset && phy_txvld && phy_txready)
      begin
         for (int k = 0; k < (1 << csr_iowidth); k++)
            rx_q.push_back(phy_txdata[8*k +: 8]);
         rx_lines++;
      end
      check_equal(64'(umi_req_in_ready && umi_resp_in_ready), 64'd0, "both readies high");
   end

   function automatic logic [31:0] make_cmd(input logic [4:0] op, input logic [2:0] size,
                                            input logic [7:0] len);
      return {16'h0000, len, size, op};
   endfunction

   // Bytes on the wire by opcode class
   function automatic int wire_bytes(input logic [31:0] cmd);
      int data_b;
      data_b = (int'(cmd[15:8]) + 1) << cmd[7:5];
      if (data_b > 8)
         data_b = 8;                                   // Data field is 8 bytes
      case (cmd[4:0])
         UMI_INVALID, UMI_REQ_LINK, UMI_RESP_LINK: return UMI_CMD_BYTES;
         UMI_REQ_READ, UMI_RESP_WRITE:             return UMI_HDR_BYTES;
         default:                                  return UMI_HDR_BYTES + data_b;
      endcase
   endfunction

   // Random fields onto one channel, expected lines onto the queue
   task automatic load_packet(input bit to_resp, input logic [31:0] cmd);
      logic [63:0]  data;
      logic [31:0]  src;
      logic [31:0]  dst;
      logic [159:0] pkt;
      int           nb;
      int           lb;
      int           nl;
      data = {lfsr_word(), lfsr_word()};
      src  = lfsr_word();
      dst  = lfsr_word();
      if (to_resp)
      begin
         umi_resp_in_cmd     = cmd;
         umi_resp_in_dstaddr = dst;
         umi_resp_in_srcaddr = src;
         umi_resp_in_data    = data;
      end
      else
      begin
         umi_req_in_cmd     = cmd;
         umi_req_in_dstaddr = dst;
         umi_req_in_srcaddr = src;
         umi_req_in_data    = data;
      end
      pkt = {data, src, dst, cmd};                     // cmd leaves first
      nb  = wire_bytes(cmd);
      lb  = 1 << csr_iowidth;
      nl  = (nb + lb - 1) / lb;                        // Round up to whole lines
      for (int i = 0; i < nl * lb; i++)
      begin
         if (i < nb)
         begin
            exp_q.push_back(pkt[8*i +: 8]);
            exp_mask.push_back(1'b1);
         end
         else
         begin
            exp_q.push_back(8'h00);                    // Padding, not compared
            exp_mask.push_back(1'b0);
         end
      end
      exp_lines += nl;
      if (to_resp)
         resp_lines_total += nl;
      else
         req_lines_total += nl;
   endtask

   // Raise valids, drop each one after its acceptance edge
   task automatic offer_packets(input bit on_req, input bit on_resp);
      bit req_acc;
      bit resp_acc;
      umi_req_in_valid  = on_req;
      umi_resp_in_valid = on_resp;
      while (umi_req_in_valid || umi_resp_in_valid)
      begin
         @(negedge clk);
         req_acc  = umi_req_in_valid && umi_req_in_ready;
         resp_acc = umi_resp_in_valid && umi_resp_in_ready;
         @(posedge clk);
         #1;
         if (req_acc)
            umi_req_in_valid = 1'b0;
         if (resp_acc)
            umi_resp_in_valid = 1'b0;
      end
   endtask

   task automatic send_one(input bit to_resp, input logic [31:0] cmd);
      load_packet(to_resp, cmd);
      offer_packets(!to_resp, to_resp);
   endtask

   // Wait for all expected lines, then compare only packet bytes
   task automatic compare_stream(input string what);
      while (rx_q.size() < exp_q.size())
         @(posedge clk);
      repeat (3) @(posedge clk);                       // Catch extra lines
      #1;
      check_equal(64'(rx_lines), 64'(exp_lines), {what, ": line count"});
      foreach (exp_q[i])
         if (exp_mask[i] && i < rx_q.size())
            check_equal(64'(rx_q[i]), 64'(exp_q[i]), $sformatf("%s: byte %0d", what, i));
      rx_q.delete();
      exp_q.delete();
      exp_mask.delete();
      rx_lines  = 0;
      exp_lines = 0;
   endtask

   //############################################################
   // Directed tests
   //############################################################
   task automatic send_at_widths();
      logic [1:0] widths[3] = '{2'd3, 2'd2, 2'd0};
      foreach (widths[w])
      begin
         csr_iowidth = widths[w];
         send_one(1'b0, make_cmd(UMI_REQ_WRITE, 3'd3, 8'd0));   // 8 data bytes
         send_one(1'b0, make_cmd(UMI_REQ_WRITE, 3'd1, 8'd1));   // 4 data bytes
         send_one(1'b0, make_cmd(UMI_REQ_POSTED, 3'd0, 8'd0));  // Partial last line
         send_one(1'b0, make_cmd(UMI_REQ_WRITE, 3'd2, 8'd3));   // 16 capped to 8
         compare_stream($sformatf("width %0d", widths[w]));
      end
   endtask

   task automatic size_by_class();
      csr_iowidth = 2'd2;
      send_one(1'b0, make_cmd(UMI_INVALID, 3'd3, 8'd7));        // 4 bytes whatever len
      send_one(1'b0, make_cmd(UMI_REQ_LINK, 3'd0, 8'd0));
      send_one(1'b0, make_cmd(UMI_REQ_READ, 3'd3, 8'd0));       // Header only
      send_one(1'b1, make_cmd(UMI_RESP_WRITE, 3'd2, 8'd0));
      compare_stream("class sizing");
   endtask

   // Response queued first in the expected stream
   task automatic resp_priority();
      load_packet(1'b1, make_cmd(UMI_RESP_READ, 3'd3, 8'd0));
      load_packet(1'b0, make_cmd(UMI_REQ_WRITE, 3'd2, 8'd0));
      offer_packets(1'b1, 1'b1);
      compare_stream("priority");
   endtask

   task automatic phy_backpressure();
      csr_iowidth = 2'd1;
      bp_en       = 1'b1;
      send_one(1'b0, make_cmd(UMI_REQ_WRITE, 3'd3, 8'd0));
      send_one(1'b1, make_cmd(UMI_RESP_READ, 3'd0, 8'd2));
      send_one(1'b0, make_cmd(UMI_REQ_READ, 3'd0, 8'd0));
      send_one(1'b1, make_cmd(UMI_RESP_LINK, 3'd0, 8'd0));
      compare_stream("back-pressure");
      bp_en = 1'b0;
   endtask

   // Both lanes one line short, response still first once credit arrives
   task automatic credit_gating();
      logic [15:0] base_req;
      logic [15:0] base_resp;
      csr_iowidth = 2'd3;
      csr_crdt_en = 1'b1;
      load_packet(1'b1, make_cmd(UMI_RESP_READ, 3'd3, 8'd0));   // 3 lines
      load_packet(1'b0, make_cmd(UMI_REQ_WRITE, 3'd3, 8'd0));   // 3 lines
      rmt_crdt_req      = 16'(req_lines_total - 1);             // One line short
      rmt_crdt_resp     = 16'(resp_lines_total - 1);
      base_req          = csr_crdt_status[15:0];
      base_resp         = csr_crdt_status[31:16];
      umi_req_in_valid  = 1'b1;
      umi_resp_in_valid = 1'b1;
      repeat (6)
      begin
         @(negedge clk);
         check_equal(64'(umi_req_in_ready), 64'd0, "req ready without credit");
         check_equal(64'(umi_resp_in_ready), 64'd0, "resp ready without credit");
         @(posedge clk);
         #1;
      end
      check_equal(64'(csr_crdt_status[15:0] - base_req), 64'd6, "req stall count");
      check_equal(64'(csr_crdt_status[31:16] - base_resp), 64'd6, "resp stall count");
      rmt_crdt_req  = 16'(req_lines_total);                     // Now enough
      rmt_crdt_resp = 16'(resp_lines_total);
      offer_packets(1'b1, 1'b1);
      compare_stream("credit");
      csr_crdt_en = 1'b0;
   endtask

   task automatic enable_gating();
      csr_iowidth = 2'd2;
      csr_en      = 1'b0;
      load_packet(1'b1, make_cmd(UMI_RESP_READ, 3'd2, 8'd1));
      umi_resp_in_valid = 1'b1;
      repeat (5)
      begin
         @(negedge clk);
         check_equal(64'(umi_resp_in_ready), 64'd0, "accepted while disabled");
         check_equal(64'(phy_txvld), 64'd0, "PHY valid while disabled");
         @(posedge clk);
         #1;
      end
      csr_en = 1'b1;
      offer_packets(1'b0, 1'b1);
      compare_stream("enable");
   endtask

   initial
   begin
      nreset              = 1'b0;
      csr_en              = 1'b1;
      csr_crdt_en         = 1'b0;
      csr_iowidth         = 2'd3;
      umi_req_in_valid    = 1'b0;
      umi_req_in_cmd      = '0;
      umi_req_in_dstaddr  = '0;
      umi_req_in_srcaddr  = '0;
      umi_req_in_data     = '0;
      umi_resp_in_valid   = 1'b0;
      umi_resp_in_cmd     = '0;
      umi_resp_in_dstaddr = '0;
      umi_resp_in_srcaddr = '0;
      umi_resp_in_data    = '0;
      rmt_crdt_req        = '0;
      rmt_crdt_resp       = '0;
      phy_txready         = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      nreset = 1'b1;
      send_at_widths();
      size_by_class();
      resp_priority();
      phy_backpressure();
      credit_gating();
      enable_gating();
      $display("Checks %0d, errors %0d, cycles %0d", check_cnt, err_cnt, cycle_cnt);
      if (err_cnt == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
source/umi_pkg.sv
source/lumi_pkg.sv
source/lumi_lane_if.sv
source/lumi_lane.sv
source/lumi_serializer.sv
source/lumi_tx.sv
tests/lumi_tx_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the link transmit testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
   --top-module lumi_tx_tb --Mdir obj_dir -o lumi_tx_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/lumi_tx_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx '>>> PASS' sim.log; then
   exit 0
fi
echo "Pass line not found in sim.log"
exit 1
